/* src/ic_defs.svh */
`ifndef IC_DEFS_SVH
`define IC_DEFS_SVH

////////////////////////////////////////////////////////////
// instruction cache sizes
////////////////////////////////////////////////////////////

// program counter and instruction widths
`define IC_PC_BITS          32
`define IC_INST_BITS        32
// byte offset bits below one instruction
`define IC_INST_BYTES_LOG   2

// line geometry, four instructions per line
`define IC_INSTS_PER_LINE   4
`define IC_OFFSET_BITS      2

// sets and ways
`define IC_SETS             16
`define IC_INDEX_BITS       4
`define IC_WAYS             4
`define IC_WAY_BITS         2

// slots handed to fetch each cycle
`define IC_FETCH_WIDTH      2

`endif

/* src/ic_pkg.sv */
`include "ic_defs.svh"

package ic_pkg;

  // tag is whatever is left above index, offset and byte bits
  localparam int TAG_BITS = `IC_PC_BITS - `IC_INDEX_BITS - `IC_OFFSET_BITS
                            - `IC_INST_BYTES_LOG;

  ////////////////////////////////////////////////////////////
  // address fields
  ////////////////////////////////////////////////////////////

  typedef logic [`IC_PC_BITS-1:0]      pc_t;
  typedef logic [TAG_BITS-1:0]         tag_t;
  typedef logic [`IC_INDEX_BITS-1:0]   index_t;
  typedef logic [`IC_OFFSET_BITS-1:0]  offset_t;
  typedef logic [`IC_WAY_BITS-1:0]     way_t;

  ////////////////////////////////////////////////////////////
  // payload
  ////////////////////////////////////////////////////////////

  typedef logic [`IC_INST_BITS-1:0]    inst_t;

  // word 0 sits in the low bits of the line
  typedef inst_t [`IC_INSTS_PER_LINE-1:0] line_t;

  // block address as sent to memory, tag above index
  typedef struct packed {
    tag_t   tag;
    index_t index;
  } blk_addr_t;

endpackage

/* src/ic_fill_if.sv */
// one line fill, miss controller to tag and data stores
interface ic_fill_if;
  import ic_pkg::*;

  logic   valid;
  index_t index;
  tag_t   tag;
  way_t   way;
  line_t  data;

  // driven by the miss controller
  modport src (output valid, output index, output tag, output way, output data);

  // tag side needs everything except the line itself
  modport tag_dst (input valid, input index, input tag, input way);

  // data side has no use for the tag
  modport data_dst (input valid, input index, input way, input data);

endinterface

/* src/ic_way_array.sv */
`include "ic_defs.svh"

module ic_way_array #(
  parameter type entry_t = logic [31:0]
) (
  input  logic            clk,
  input  logic            reset,
  input  logic            wr_en_i,
  input  ic_pkg::way_t    wr_way_i,
  input  ic_pkg::index_t  wr_index_i,
  input  entry_t          wr_data_i,
  input  ic_pkg::index_t  rd_index_i,
  output entry_t          rd_data_o [`IC_WAYS]
);

  // one entry per way and set
  entry_t mem_q [`IC_WAYS][`IC_SETS];

  // single write port, one way per edge
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      for (int w = 0; w < `IC_WAYS; w++)
      begin
        for (int s = 0; s < `IC_SETS; s++)
          mem_q[w][s] <= '0;
      end
    end
    else if (wr_en_i)
    begin
      mem_q[wr_way_i][wr_index_i] <= wr_data_i;
    end
  end

  // all ways of the addressed set, no read latency
  for (genvar w = 0; w < `IC_WAYS; w++)
  begin : g_rd
    assign rd_data_o[w] = mem_q[w][rd_index_i];
  end

endmodule

/* src/ic_tag_match.sv */
`include "ic_defs.svh"

module ic_tag_match (
  input  logic                 clk,
  input  logic                 reset,
  ic_fill_if.tag_dst           fill,
  input  logic                 fetch_req_i,
  input  ic_pkg::index_t       index_i,
  input  ic_pkg::tag_t         tag_i,
  input  logic                 flush_i,
  input  logic                 inv_i,
  input  ic_pkg::index_t       inv_index_i,
  output logic [`IC_WAYS-1:0]  hit_o
);
  import ic_pkg::*;

  // tags read for the current fetch set
  tag_t rd_tags [`IC_WAYS];

  // valid bits, one word of ways per set
  logic [`IC_WAYS-1:0] valid_q [`IC_SETS];
  logic [`IC_WAYS-1:0] set_valid;

  ////////////////////////////////////////////////////////////
  // tag storage
  ////////////////////////////////////////////////////////////

  // tag is written with the fill, valid bit tracked separately
  ic_way_array #(
    .entry_t    (tag_t)
  ) tag_store (
    .clk        (clk),
    .reset      (reset),
    .wr_en_i    (fill.valid),
    .wr_way_i   (fill.way),
    .wr_index_i (fill.index),
    .wr_data_i  (fill.tag),
    .rd_index_i (index_i),
    .rd_data_o  (rd_tags)
  );

  ////////////////////////////////////////////////////////////
  // valid bits
  ////////////////////////////////////////////////////////////

  // flush beats invalidate beats fill
  // a fill landing with a flush or invalidate is dropped
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      for (int s = 0; s < `IC_SETS; s++)
        valid_q[s] <= '0;
    end
    else if (flush_i)
    begin
      for (int s = 0; s < `IC_SETS; s++)
        valid_q[s] <= '0;
    end
    else if (inv_i)
    begin
      // whole set goes, every way
      valid_q[inv_index_i] <= '0;
    end
    else if (fill.valid)
    begin
      valid_q[fill.index][fill.way] <= 1'b1;
    end
  end

  assign set_valid = valid_q[index_i];

  // per-way compare, only while fetch is asking
  always_comb
  begin
    for (int w = 0; w < `IC_WAYS; w++)
      hit_o[w] = fetch_req_i & set_valid[w] & (rd_tags[w] == tag_i);
  end

endmodule

/* src/ic_fetch_select.sv */
`include "ic_defs.svh"

module ic_fetch_select (
  input  logic [`IC_WAYS-1:0]         hit_i,
  input  ic_pkg::line_t               lines_i [`IC_WAYS],
  input  ic_pkg::offset_t             offset_i,
  output ic_pkg::inst_t               inst_o [`IC_FETCH_WIDTH],
  output logic [`IC_FETCH_WIDTH-1:0]  inst_valid_o,
  output logic                        any_hit_o
);
  import ic_pkg::*;

  // line of the winning way
  line_t sel_line;

  assign any_hit_o = |hit_i;

  // walk from the top so the lowest hitting way wins
  always_comb
  begin
    sel_line = '0;
    for (int w = `IC_WAYS-1; w >= 0; w--)
    begin
      if (hit_i[w])
        sel_line = lines_i[w];
    end
  end

  ////////////////////////////////////////////////////////////
  // slot steering
  ////////////////////////////////////////////////////////////

  for (genvar i = 0; i < `IC_FETCH_WIDTH; i++)
  begin : g_slot
    // word index wraps inside the line, slot is invalid then anyway
    offset_t word_idx;

    assign word_idx  = offset_i + offset_t'(i);
    assign inst_o[i] = sel_line[word_idx];

    // slot 0 on any hit, later slots only while still inside the line
    assign inst_valid_o[i] = any_hit_o & ((int'(offset_i) + i) < `IC_INSTS_PER_LINE);
  end

endmodule

/* src/ic_miss_ctrl.sv */
`include "ic_defs.svh"

module ic_miss_ctrl (
  input  logic               clk,
  input  logic               reset,
  input  logic               fetch_req_i,
  input  logic               any_hit_i,
  input  ic_pkg::index_t     index_i,
  input  ic_pkg::tag_t       tag_i,
  output ic_pkg::blk_addr_t  mem_req_addr_o,
  output logic               mem_req_valid_o,
  input  logic               mem_resp_valid_i,
  input  ic_pkg::tag_t       mem_resp_tag_i,
  input  ic_pkg::index_t     mem_resp_index_i,
  input  ic_pkg::line_t      mem_resp_data_i,
  output logic               miss_o,
  ic_fill_if.src             fill
);
  import ic_pkg::*;

  // fetch fields one cycle late, source of the request
  tag_t      tag_q;
  index_t    index_q;

  logic      miss;
  logic      miss_d1;
  logic      miss_d2;
  logic      miss_pulse;
  logic      req;
  way_t      req_way;

  // single MSHR
  logic      mshr_valid_q;
  blk_addr_t mshr_addr_q;
  way_t      mshr_way_q;
  logic      resp_match;

  // registered fill record
  logic      fill_valid_q;
  index_t    fill_index_q;
  tag_t      fill_tag_q;
  way_t      fill_way_q;
  line_t     fill_data_q;

  // next victim per set
  way_t      rr_q [`IC_SETS];

  ////////////////////////////////////////////////////////////
  // miss pulse and request
  ////////////////////////////////////////////////////////////

  assign miss = fetch_req_i & ~any_hit_i;

  // a fill drops the chain for a cycle, so a held miss pulses again
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      miss_d1 <= 1'b0;
      miss_d2 <= 1'b0;
    end
    else
    begin
      miss_d1 <= miss & ~fill_valid_q;
      miss_d2 <= miss_d1 & ~fill_valid_q;
    end
  end

  // rising edge of the delayed miss
  assign miss_pulse = miss_d1 & ~miss_d2;

  always_ff @(posedge clk)
  begin
    tag_q   <= tag_i;
    index_q <= index_i;
  end

  // only with a free MSHR, or one being freed by this cycle's fill
  assign req             = miss_pulse & (~mshr_valid_q | fill_valid_q);
  assign mem_req_valid_o = req;
  assign mem_req_addr_o  = '{tag: tag_q, index: index_q};
  assign miss_o          = req;

  // a fill to the same set this cycle already took the current way
  assign req_way = (fill_valid_q && (fill_index_q == index_q))
                   ? way_t'(rr_q[index_q] + 1'b1)
                   : rr_q[index_q];

  ////////////////////////////////////////////////////////////
  // MSHR
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      mshr_valid_q <= 1'b0;
    else if (req)
      mshr_valid_q <= 1'b1;
    else if (fill_valid_q)
      mshr_valid_q <= 1'b0;
  end

  always_ff @(posedge clk)
  begin
    if (req)
    begin
      mshr_addr_q <= '{tag: tag_q, index: index_q};
      mshr_way_q  <= req_way;
    end
  end

  // response must match the outstanding block exactly
  assign resp_match = mem_resp_valid_i & mshr_valid_q
                      & (mem_resp_tag_i == mshr_addr_q.tag)
                      & (mem_resp_index_i == mshr_addr_q.index);

  ////////////////////////////////////////////////////////////
  // fill record and round robin
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      fill_valid_q <= 1'b0;
    else
      fill_valid_q <= resp_match;
  end

  always_ff @(posedge clk)
  begin
    fill_index_q <= mshr_addr_q.index;
    fill_tag_q   <= mshr_addr_q.tag;
    fill_way_q   <= mshr_way_q;
    fill_data_q  <= mem_resp_data_i;
  end

  // pointer moves once per fill, not per miss cycle
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      for (int s = 0; s < `IC_SETS; s++)
        rr_q[s] <= '0;
    end
    else if (fill_valid_q)
    begin
      rr_q[fill_index_q] <= rr_q[fill_index_q] + 1'b1;
    end
  end

  assign fill.valid = fill_valid_q;
  assign fill.index = fill_index_q;
  assign fill.tag   = fill_tag_q;
  assign fill.way   = fill_way_q;
  assign fill.data  = fill_data_q;

endmodule

/* src/ic_top.sv */
`include "ic_defs.svh"

module ic_top (
  input  logic                        clk,
  input  logic                        reset,

  // fetch stage
  input  logic                        fetch_req_i,
  input  ic_pkg::pc_t                 pc_i,
  output ic_pkg::inst_t               inst_o [`IC_FETCH_WIDTH],
  output logic [`IC_FETCH_WIDTH-1:0]  inst_valid_o,

  // memory request
  output ic_pkg::blk_addr_t           mem_req_addr_o,
  output logic                        mem_req_valid_o,

  // memory response
  input  logic                        mem_resp_valid_i,
  input  ic_pkg::tag_t                mem_resp_tag_i,
  input  ic_pkg::index_t              mem_resp_index_i,
  input  ic_pkg::line_t               mem_resp_data_i,

  // invalidate and flush
  input  logic                        inv_i,
  input  ic_pkg::index_t              inv_index_i,
  input  logic                        flush_i,
  output logic                        flush_done_o,

  output logic                        miss_o
);
  import ic_pkg::*;

  // pc fields
  tag_t    pc_tag;
  index_t  pc_index;
  offset_t pc_offset;

  logic [`IC_WAYS-1:0] hit;
  logic                any_hit;
  line_t               lines [`IC_WAYS];

  ic_fill_if fill_bus ();

  ////////////////////////////////////////////////////////////
  // pc split, byte bits dropped
  ////////////////////////////////////////////////////////////

  assign pc_offset = pc_i[`IC_INST_BYTES_LOG +: `IC_OFFSET_BITS];
  assign pc_index  = pc_i[`IC_INST_BYTES_LOG + `IC_OFFSET_BITS +: `IC_INDEX_BITS];
  assign pc_tag    = pc_i[`IC_PC_BITS-1 -: TAG_BITS];

  ////////////////////////////////////////////////////////////
  // lookup, tags and data side by side
  ////////////////////////////////////////////////////////////

  ic_tag_match u_tag_match (
    .clk         (clk),
    .reset       (reset),
    .fill        (fill_bus.tag_dst),
    .fetch_req_i (fetch_req_i),
    .index_i     (pc_index),
    .tag_i       (pc_tag),
    .flush_i     (flush_i),
    .inv_i       (inv_i),
    .inv_index_i (inv_index_i),
    .hit_o       (hit)
  );

  // data side of the fill bus
  ic_way_array #(
    .entry_t    (line_t)
  ) data_store (
    .clk        (clk),
    .reset      (reset),
    .wr_en_i    (fill_bus.valid),
    .wr_way_i   (fill_bus.way),
    .wr_index_i (fill_bus.index),
    .wr_data_i  (fill_bus.data),
    .rd_index_i (pc_index),
    .rd_data_o  (lines)
  );

  ic_fetch_select u_fetch_select (
    .hit_i        (hit),
    .lines_i      (lines),
    .offset_i     (pc_offset),
    .inst_o       (inst_o),
    .inst_valid_o (inst_valid_o),
    .any_hit_o    (any_hit)
  );

  ////////////////////////////////////////////////////////////
  // miss handling
  ////////////////////////////////////////////////////////////

  ic_miss_ctrl u_miss_ctrl (
    .clk              (clk),
    .reset            (reset),
    .fetch_req_i      (fetch_req_i),
    .any_hit_i        (any_hit),
    .index_i          (pc_index),
    .tag_i            (pc_tag),
    .mem_req_addr_o   (mem_req_addr_o),
    .mem_req_valid_o  (mem_req_valid_o),
    .mem_resp_valid_i (mem_resp_valid_i),
    .mem_resp_tag_i   (mem_resp_tag_i),
    .mem_resp_index_i (mem_resp_index_i),
    .mem_resp_data_i  (mem_resp_data_i),
    .miss_o           (miss_o),
    .fill             (fill_bus.src)
  );

  // valid bits clear in one edge, so done follows a cycle later
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      flush_done_o <= 1'b0;
    else
      flush_done_o <= flush_i;
  end

endmodule

/* test/ic_chk.sv */
`include "ic_defs.svh"

module ic_chk (
  input logic                        clk,
  input logic                        reset,
  input logic                        fetch_req_i,
  input ic_pkg::pc_t                 pc_i,
  input ic_pkg::inst_t               inst_i [`IC_FETCH_WIDTH],
  input logic [`IC_FETCH_WIDTH-1:0]  inst_valid_i,
  input ic_pkg::blk_addr_t           req_addr_i,
  input logic                        req_valid_i,
  input logic                        resp_valid_i,
  input ic_pkg::tag_t                resp_tag_i,
  input ic_pkg::index_t              resp_index_i,
  input logic                        inv_i,
  input ic_pkg::index_t              inv_index_i,
  input logic                        flush_i,
  input logic                        flush_done_i,
  input logic                        miss_i
);
  import ic_pkg::*;

  // bumped by every failing property
  int unsigned fail_cnt = 0;

  // fetch pc seen as block, word and set
  blk_addr_t pc_blk;
  inst_t     pc_word;
  index_t    pc_index;

  // shadow of the single outstanding request
  logic      pend_q;
  blk_addr_t pend_addr_q;
  logic      resp_acc;

  // accepted response, two cycles of history
  logic      acc_d1;
  logic      acc_d2;
  blk_addr_t acc_addr_d1;
  blk_addr_t acc_addr_d2;
  logic      clr_d1;

  assign pc_blk   = blk_addr_t'(pc_i[`IC_PC_BITS-1:`IC_OFFSET_BITS+`IC_INST_BYTES_LOG]);
  assign pc_word  = inst_t'(pc_i >> `IC_INST_BYTES_LOG);
  assign pc_index = pc_i[`IC_INST_BYTES_LOG + `IC_OFFSET_BITS +: `IC_INDEX_BITS];

  // response counts only against the pending block
  assign resp_acc = resp_valid_i & pend_q & ({resp_tag_i, resp_index_i} == pend_addr_q);

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      pend_q <= 1'b0;
      acc_d1 <= 1'b0;
      acc_d2 <= 1'b0;
      clr_d1 <= 1'b0;
    end
    else
    begin
      if (req_valid_i)
        pend_q <= 1'b1;
      else if (resp_acc)
        pend_q <= 1'b0;
      acc_d1 <= resp_acc;
      acc_d2 <= acc_d1;
      // a flush or invalidate here drops the fill
      clr_d1 <= inv_i | flush_i;
    end
  end

  always_ff @(posedge clk)
  begin
    if (req_valid_i)
      pend_addr_q <= req_addr_i;
    acc_addr_d1 <= pend_addr_q;
    acc_addr_d2 <= acc_addr_d1;
  end

  ////////////////////////////////////////////////////////////
  // slot contents
  ////////////////////////////////////////////////////////////

  // memory holds the word address in every word
  a_slot0_data : assert property (@(posedge clk) disable iff (reset)
    inst_valid_i[0] |-> inst_i[0] == pc_word)
    else begin fail_cnt++; $error("slot 0 returned the wrong instruction"); end

  a_slot1_data : assert property (@(posedge clk) disable iff (reset)
    inst_valid_i[1] |-> inst_i[1] == pc_word + 32'd1)
    else begin fail_cnt++; $error("slot 1 returned the wrong instruction"); end

  // slot 1 only while the next word is still in the line
  a_slot1_valid : assert property (@(posedge clk) disable iff (reset)
    inst_valid_i[1] == (inst_valid_i[0]
                        && pc_i[`IC_INST_BYTES_LOG +: `IC_OFFSET_BITS] != 2'd3))
    else begin fail_cnt++; $error("slot 1 valid disagrees with slot 0 and offset"); end

  ////////////////////////////////////////////////////////////
  // miss handling
  ////////////////////////////////////////////////////////////

  a_req_addr : assert property (@(posedge clk) disable iff (reset)
    req_valid_i |-> $past(fetch_req_i) && req_addr_i == $past(pc_blk))
    else begin fail_cnt++; $error("request address is not the missing fetch block"); end

  a_single_miss : assert property (@(posedge clk) disable iff (reset)
    req_valid_i |-> !pend_q)
    else begin fail_cnt++; $error("second request while one is outstanding"); end

  // miss output is the request pulse itself
  a_miss_pulse : assert property (@(posedge clk) disable iff (reset)
    miss_i == req_valid_i)
    else begin fail_cnt++; $error("miss output differs from the memory request"); end

  // fill lands at the end of t+1, lookup hits in t+2
  a_fill_hit : assert property (@(posedge clk) disable iff (reset)
    acc_d2 && !clr_d1 && fetch_req_i && pc_blk == acc_addr_d2 |-> inst_valid_i[0])
    else begin fail_cnt++; $error("held fetch did not hit two cycles after the response"); end

  ////////////////////////////////////////////////////////////
  // flush and invalidate
  ////////////////////////////////////////////////////////////

  a_flush_done : assert property (@(posedge clk) disable iff (reset)
    flush_done_i == $past(flush_i))
    else begin fail_cnt++; $error("flush done is not flush delayed by one cycle"); end

  a_flush_clear : assert property (@(posedge clk) disable iff (reset)
    $past(flush_i) |-> inst_valid_i == '0)
    else begin fail_cnt++; $error("fetch hit right after a flush"); end

  a_inv_clear : assert property (@(posedge clk) disable iff (reset)
    $past(inv_i) && pc_index == $past(inv_index_i) |-> inst_valid_i == '0)
    else begin fail_cnt++; $error("fetch hit in a set just invalidated"); end

endmodule

/* test/tb_top.sv */
`include "ic_defs.svh"

module tb_top;
  import ic_pkg::*;

  localparam int     DRIVE_DLY    = 10;
  localparam int     HIT_TIMEOUT  = 40;
  localparam int     RAND_FETCHES = 40;
  localparam index_t RR_SET       = 4'd9;
  localparam index_t MUM_SET      = 4'd12;

  logic                       clk;
  logic                       reset;
  logic                       fetch_req;
  pc_t                        pc;
  inst_t                      inst [`IC_FETCH_WIDTH];
  logic [`IC_FETCH_WIDTH-1:0] inst_valid;
  blk_addr_t                  req_addr;
  logic                       req_valid;
  logic                       inv;
  index_t                     inv_index;
  logic                       flush;
  logic                       flush_done;
  logic                       miss;

  // driven by the memory model only
  logic   resp_valid = 1'b0;
  tag_t   resp_tag = '0;
  index_t resp_index = '0;
  line_t  resp_data = '0;
  logic   mem_busy = 1'b0;

  int tb_errs;
  int tests_run;
  int tests_failed;
  int errs_at_start;

  ic_top uut (
    .clk              (clk),
    .reset            (reset),
    .fetch_req_i      (fetch_req),
    .pc_i             (pc),
    .inst_o           (inst),
    .inst_valid_o     (inst_valid),
    .mem_req_addr_o   (req_addr),
    .mem_req_valid_o  (req_valid),
    .mem_resp_valid_i (resp_valid),
    .mem_resp_tag_i   (resp_tag),
    .mem_resp_index_i (resp_index),
    .mem_resp_data_i  (resp_data),
    .inv_i            (inv),
    .inv_index_i      (inv_index),
    .flush_i          (flush),
    .flush_done_o     (flush_done),
    .miss_o           (miss)
  );

  bind ic_top ic_chk u_chk (
    .clk          (clk),
    .reset        (reset),
    .fetch_req_i  (fetch_req_i),
    .pc_i         (pc_i),
    .inst_i       (inst_o),
    .inst_valid_i (inst_valid_o),
    .req_addr_i   (mem_req_addr_o),
    .req_valid_i  (mem_req_valid_o),
    .resp_valid_i (mem_resp_valid_i),
    .resp_tag_i   (mem_resp_tag_i),
    .resp_index_i (mem_resp_index_i),
    .inv_i        (inv_i),
    .inv_index_i  (inv_index_i),
    .flush_i      (flush_i),
    .flush_done_i (flush_done_o),
    .miss_i       (miss_o)
  );

  always #50 clk = ~clk;

  ////////////////////////////////////////////////////////////
  // memory model
  ////////////////////////////////////////////////////////////

  // answers 1 to 4 cycles after the request, word j = block * 4 + j
  always
  begin
    blk_addr_t addr;
    int unsigned delay;
    @(negedge clk);
    if (!reset && req_valid)
    begin
      addr = req_addr;
      delay = $urandom_range(4, 1);
      mem_busy = 1'b1;
      repeat (delay) @(posedge clk);
      #DRIVE_DLY;
      resp_valid = 1'b1;
      resp_tag = addr.tag;
      resp_index = addr.index;
      for (int j = 0; j < `IC_INSTS_PER_LINE; j++)
        resp_data[j] = inst_t'({addr, 2'b00}) + inst_t'(j);
      @(posedge clk);
      #DRIVE_DLY;
      resp_valid = 1'b0;
      mem_busy = 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////

  task automatic drive_fetch(input logic req, input pc_t addr);
    @(posedge clk);
    #DRIVE_DLY;
    fetch_req = req;
    pc = addr;
  endtask

  task automatic expect_value(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
    if (act !== exp)
    begin
      $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
      tb_errs++;
    end
  endtask

  // hold the fetch until slot 0 is valid
  task automatic fetch_until_hit(input string name, input pc_t addr);
    int n;
    n = 0;
    drive_fetch(1'b1, addr);
    @(negedge clk);
    while (!inst_valid[0] && n < HIT_TIMEOUT)
    begin
      @(negedge clk);
      n++;
    end
    if (!inst_valid[0])
    begin
      $display("%s: fetch at pc %h never hit within %0d cycles", name, addr, HIT_TIMEOUT);
      tb_errs++;
    end
  endtask

  // let a stray miss finish its fill
  task automatic wait_mem_idle(input string name);
    int n;
    n = 0;
    repeat (2) @(negedge clk);
    while (mem_busy && n < HIT_TIMEOUT)
    begin
      @(negedge clk);
      n++;
    end
    if (mem_busy)
    begin
      $display("%s: memory response still pending after %0d cycles", name, HIT_TIMEOUT);
      tb_errs++;
    end
    repeat (2) @(negedge clk);
  endtask

  // five tags in one set, offset 1
  function automatic pc_t rr_pc(input int k);
    return {tag_t'(24'h100 + k), RR_SET, 4'h4};
  endfunction

  task automatic mark_test_start();
    errs_at_start = tb_errs + int'(uut.u_chk.fail_cnt);
  endtask

  task automatic report_test(input string name);
    tests_run++;
    if (tb_errs + int'(uut.u_chk.fail_cnt) != errs_at_start)
    begin
      tests_failed++;
      $display("test %s: failed", name);
    end
    else
      $display("test %s: ok", name);
  endtask

  ////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////

  initial
  begin
    pc_t a;
    pc_t b;
    void'($urandom(32'hbf55));
    clk = 1'b0;
    reset = 1'b1;
    fetch_req = 1'b0;
    pc = '0;
    inv = 1'b0;
    inv_index = '0;
    flush = 1'b0;
    tb_errs = 0;
    tests_run = 0;
    tests_failed = 0;
    repeat (3) @(posedge clk);
    #DRIVE_DLY;
    reset = 1'b0;

    // idle outputs, then a cold miss
    mark_test_start();
    @(negedge clk);
    expect_value("reset_state", 0, 32'(inst_valid));
    expect_value("reset_state", 0, 32'(req_valid));
    expect_value("reset_state", 0, 32'(flush_done));
    drive_fetch(1'b1, 32'h40);
    @(negedge clk);
    expect_value("reset_state", 0, 32'(inst_valid[0]));
    fetch_until_hit("reset_state", 32'h40);
    report_test("reset_state");

    // small window, so lines get reused
    mark_test_start();
    for (int k = 0; k < RAND_FETCHES; k++)
    begin
      a = pc_t'($urandom_range(255, 0)) << 2;
      fetch_until_hit("random_fetch", a);
    end
    report_test("random_fetch");

    mark_test_start();
    a = 32'h1230;
    fetch_until_hit("flush", a);
    @(posedge clk);
    #DRIVE_DLY;
    fetch_req = 1'b0;
    flush = 1'b1;
    @(posedge clk);
    #DRIVE_DLY;
    flush = 1'b0;
    fetch_req = 1'b1;
    @(negedge clk);
    expect_value("flush", 0, 32'(inst_valid));
    expect_value("flush", 1, 32'(flush_done));
    fetch_until_hit("flush", a);
    report_test("flush");

    mark_test_start();
    a = 32'h2350;
    fetch_until_hit("invalidate", a);
    @(posedge clk);
    #DRIVE_DLY;
    fetch_req = 1'b0;
    inv = 1'b1;
    inv_index = a[`IC_INST_BYTES_LOG + `IC_OFFSET_BITS +: `IC_INDEX_BITS];
    @(posedge clk);
    #DRIVE_DLY;
    inv = 1'b0;
    fetch_req = 1'b1;
    @(negedge clk);
    expect_value("invalidate", 0, 32'(inst_valid));
    fetch_until_hit("invalidate", a);
    report_test("invalidate");

    // second miss in the same set while the first is still outstanding
    // it has to wait for the first fill and must not overwrite its way
    mark_test_start();
    for (int k = 0; k < 4; k++)
    begin
      a = {tag_t'(24'h200 + 2 * k), MUM_SET, 4'h8};
      b = {tag_t'(24'h201 + 2 * k), MUM_SET, 4'h8};
      drive_fetch(1'b1, a);
      drive_fetch(1'b0, a);
      fetch_until_hit("miss_under_miss", b);
      drive_fetch(1'b1, a);
      @(negedge clk);
      expect_value("miss_under_miss", 1, 32'(inst_valid[0]));
      drive_fetch(1'b0, a);
      wait_mem_idle("miss_under_miss");
    end
    report_test("miss_under_miss");

    // E lands on A's way, B to E must survive
    mark_test_start();
    for (int k = 0; k < 5; k++)
      fetch_until_hit("round_robin", rr_pc(k));
    for (int k = 1; k < 5; k++)
    begin
      drive_fetch(1'b1, rr_pc(k));
      @(negedge clk);
      expect_value("round_robin", 1, 32'(inst_valid[0]));
    end
    drive_fetch(1'b1, rr_pc(0));
    @(negedge clk);
    expect_value("round_robin", 0, 32'(inst_valid[0]));
    drive_fetch(1'b0, rr_pc(0));
    wait_mem_idle("round_robin");
    report_test("round_robin");

    $display("%0d tests run, %0d failed, %0d testbench errors, %0d assertion errors",
             tests_run, tests_failed, tb_errs, uut.u_chk.fail_cnt);
    if (tests_failed == 0 && tb_errs == 0 && uut.u_chk.fail_cnt == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

/* tb.f */
+incdir+src
src/ic_pkg.sv
src/ic_fill_if.sv
src/ic_way_array.sv
src/ic_tag_match.sv
src/ic_fetch_select.sv
src/ic_miss_ctrl.sv
src/ic_top.sv
test/ic_chk.sv
test/tb_top.sv

/* run.sh */
#!/bin/sh
# build and run the instruction cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_top -o tb_sim
status=$?
if [ $status -ne 0 ]; then
  echo "build failed with status $status"
  exit 1
fi

# keep going after assertion errors so the testbench can count them
./obj_dir/tb_sim +verilator+error+limit+10000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q '^>>> PASS$' sim.log; then
  exit 0
fi
exit 1
